/* common/ext_bus_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, address map, latencies, register-bus structs and the
// slow memory state encoding for the external peripheral subsystem
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ext_bus_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Address map, one 4 KiB window per peripheral
  localparam int N_PERIPH        = 3;
  localparam int MEM_IDX         = 0;
  localparam int GPIO_CNT_IDX    = 1;
  localparam int INTR_IDX        = 2;
  localparam int WINDOW_BITS     = 12;
  localparam int WINDOW_NUM_BITS = 4;
  localparam int PERIPH_IDX_W    = $clog2(N_PERIPH);

  // Slow memory
  localparam int SLOW_MEM_WORDS   = 256;
  localparam int SLOW_MEM_ADDR_W  = $clog2(SLOW_MEM_WORDS);
  localparam int SLOW_MEM_LATENCY = 3;
  localparam int MEM_LAT_CNT_W    = $clog2(SLOW_MEM_LATENCY);

  // Power switches and interrupts
  localparam int SWITCH_ACK_LATENCY = 15;
  localparam int EXT_DOMAINS        = 2;
  localparam int NEXT_INT           = 4;
  localparam int INTR_GPIO_BIT      = 0;
  localparam int INTR_SWITCH_BIT    = 1;

  // GPIO counter
  localparam int GPIO_CNT_MAX = 8;
  localparam int GPIO_CNT_W   = $clog2(GPIO_CNT_MAX);

  typedef logic [ADDR_W-1:0]          addr_t;
  typedef logic [DATA_W-1:0]          data_t;
  typedef logic [STRB_W-1:0]          strb_t;
  typedef logic [EXT_DOMAINS-1:0]     domain_vec_t;
  typedef logic [NEXT_INT-1:0]        intr_vec_t;
  typedef logic [WINDOW_NUM_BITS-1:0] window_t;
  typedef logic [PERIPH_IDX_W-1:0]    periph_idx_t;
  typedef logic [WINDOW_BITS-1:0]     offset_t;
  typedef logic [SLOW_MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [MEM_LAT_CNT_W-1:0]   lat_cnt_t;
  typedef logic [GPIO_CNT_W-1:0]      gpio_cnt_t;

  // Register offsets inside a window
  localparam offset_t GPIO_CNT_OFFSET     = offset_t'(0);
  localparam offset_t INTR_PENDING_OFFSET = offset_t'(0);
  localparam offset_t INTR_ENABLE_OFFSET  = offset_t'(4);

  // Only the GPIO and switch sources exist
  localparam intr_vec_t INTR_IMPL_MASK =
      intr_vec_t'((1 << INTR_GPIO_BIT) | (1 << INTR_SWITCH_BIT));

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
    logic  ready;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    WAIT = 2'd1,
    DONE = 2'd2
  } mem_state_e;

endpackage

`default_nettype wire

/* source/reg_demux.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register-bus window decode, request steering and response select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module reg_demux import ext_bus_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  reg_req_t                req_i,
  output reg_rsp_t                rsp_o,
  output reg_req_t [N_PERIPH-1:0] periph_req_o,
  input  reg_rsp_t [N_PERIPH-1:0] periph_rsp_i
);

  window_t     dec_window;
  logic        dec_hit;
  periph_idx_t sel_idx;
  logic        sel_hit;
  logic        in_flight_q;
  periph_idx_t sel_idx_q;
  logic        sel_hit_q;

  // Upper address bits must be clear for any mapped window
  assign dec_window = req_i.addr[WINDOW_BITS +: WINDOW_NUM_BITS];
  assign dec_hit    = (req_i.addr[ADDR_W-1:WINDOW_BITS+WINDOW_NUM_BITS] == '0) &&
                      (int'(dec_window) < N_PERIPH);

  // Selection stays locked while a memory wait is in progress
  assign sel_idx = in_flight_q ? sel_idx_q : dec_window[PERIPH_IDX_W-1:0];
  assign sel_hit = in_flight_q ? sel_hit_q : dec_hit;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_flight_q <= 1'b0;
    end else if (req_i.valid && !rsp_o.ready) begin
      in_flight_q <= 1'b1;
    end else begin
      in_flight_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    sel_idx_q <= sel_idx;
    sel_hit_q <= sel_hit;
  end

  always_comb begin
    for (int i = 0; i < N_PERIPH; i++) begin
      periph_req_o[i]       = req_i;
      periph_req_o[i].valid = req_i.valid && sel_hit && (int'(sel_idx) == i);
    end
  end

  always_comb begin
    if (sel_hit) begin
      rsp_o = periph_rsp_i[sel_idx];
    end else begin
      // Unmapped window answers at once with an error
      rsp_o       = '0;
      rsp_o.error = req_i.valid;
      rsp_o.ready = req_i.valid;
    end
  end

endmodule

`default_nettype wire

/* slow_memory/slow_memory.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register-bus word memory with byte strobes and a fixed response
// latency controlled by a small FSM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module slow_memory import ext_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o
);

  data_t      mem_q [SLOW_MEM_WORDS];
  mem_state_e state_q;
  lat_cnt_t   lat_cnt_q;
  data_t      rdata_q;
  mem_addr_t  word_idx;
  logic       lat_done;

  // Offsets above the array depth alias onto the same words
  assign word_idx = req_i.addr[SLOW_MEM_ADDR_W+1:2];
  assign lat_done = (state_q == WAIT) && (lat_cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      lat_cnt_q <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (req_i.valid) begin
            state_q   <= WAIT;
            // Two of the latency edges are the IDLE exit and the DONE entry
            lat_cnt_q <= lat_cnt_t'(SLOW_MEM_LATENCY - 2);
          end
        end
        WAIT: begin
          if (lat_done) begin
            state_q <= DONE;
          end else begin
            lat_cnt_q <= lat_cnt_q - lat_cnt_t'(1);
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Read data is fetched on the edge that enters DONE
  always_ff @(posedge clk_i) begin
    if (lat_done) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  // Strobed write on the ready cycle
  always_ff @(posedge clk_i) begin
    if ((state_q == DONE) && req_i.valid && req_i.write) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.wstrb[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    rsp_o       = '0;
    rsp_o.ready = (state_q == DONE);
    if (rsp_o.ready && !req_i.write) begin
      rsp_o.rdata = rdata_q;
    end
  end

endmodule

`default_nettype wire

/* source/gpio_cnt.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO rising-edge counter with toggling output and count register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module gpio_cnt import ext_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     gpio_i,
  output logic     gpio_o,
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o,
  output logic     cnt_event_o
);

  gpio_cnt_t cnt_q;
  logic      gpio_q;
  logic      rise;
  logic      at_limit;
  logic      cnt_sel;
  logic      cnt_clr;

  assign rise     = gpio_i && !gpio_q;
  assign at_limit = (cnt_q == gpio_cnt_t'(GPIO_CNT_MAX - 1));
  assign cnt_sel  = (req_i.addr[WINDOW_BITS-1:0] == GPIO_CNT_OFFSET);
  assign cnt_clr  = req_i.valid && req_i.write && cnt_sel;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_q      <= 1'b0;
      cnt_q       <= '0;
      gpio_o      <= 1'b0;
      cnt_event_o <= 1'b0;
    end else begin
      gpio_q      <= gpio_i;
      cnt_event_o <= 1'b0;
      // A bus clear takes priority over a coincident edge
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (rise) begin
        if (at_limit) begin
          cnt_q       <= '0;
          gpio_o      <= !gpio_o;
          cnt_event_o <= 1'b1;
        end else begin
          cnt_q <= cnt_q + gpio_cnt_t'(1);
        end
      end
    end
  end

  always_comb begin
    rsp_o       = '0;
    rsp_o.ready = req_i.valid;
    if (cnt_sel && !req_i.write) begin
      rsp_o.rdata = data_t'(cnt_q);
    end
  end

endmodule

`default_nettype wire

/* source/switch_ack_delay.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Power-switch acknowledge delay line and acknowledge change pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module switch_ack_delay import ext_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  domain_vec_t switch_n_i,
  output domain_vec_t switch_ack_n_o,
  output logic        ack_event_o
);

  domain_vec_t [SWITCH_ACK_LATENCY-1:0] stage_q;

  // Switches start off, so the line fills with ones
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stage_q     <= '1;
      ack_event_o <= 1'b0;
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
      // Pulse lands in the cycle where the acknowledge changes
      ack_event_o <= (stage_q[SWITCH_ACK_LATENCY-1] != stage_q[SWITCH_ACK_LATENCY-2]);
    end
  end

  assign switch_ack_n_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

`default_nettype wire

/* source/intr_collect.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt pending and enable registers with masked vector output
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module intr_collect import ext_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      cnt_event_i,
  input  logic      ack_event_i,
  input  reg_req_t  req_i,
  output reg_rsp_t  rsp_o,
  output intr_vec_t intr_o
);

  intr_vec_t pending_q;
  intr_vec_t enable_q;
  intr_vec_t set_vec;
  intr_vec_t clr_vec;
  logic      pend_sel;
  logic      en_sel;
  logic      bus_wr;

  assign pend_sel = (req_i.addr[WINDOW_BITS-1:0] == INTR_PENDING_OFFSET);
  assign en_sel   = (req_i.addr[WINDOW_BITS-1:0] == INTR_ENABLE_OFFSET);
  assign bus_wr   = req_i.valid && req_i.write;

  always_comb begin
    set_vec                  = '0;
    set_vec[INTR_GPIO_BIT]   = cnt_event_i;
    set_vec[INTR_SWITCH_BIT] = ack_event_i;
  end

  // Write one to clear
  assign clr_vec = (bus_wr && pend_sel) ? req_i.wdata[NEXT_INT-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      intr_o    <= '0;
    end else begin
      // New events win over a clear in the same cycle
      pending_q <= (pending_q & ~clr_vec) | set_vec;
      if (bus_wr && en_sel) begin
        enable_q <= req_i.wdata[NEXT_INT-1:0] & INTR_IMPL_MASK;
      end
      intr_o <= pending_q & enable_q;
    end
  end

  always_comb begin
    rsp_o       = '0;
    rsp_o.ready = req_i.valid;
    if (!req_i.write) begin
      if (pend_sel) begin
        rsp_o.rdata = data_t'(pending_q);
      end else if (en_sel) begin
        rsp_o.rdata = data_t'(enable_q);
      end
    end
  end

endmodule

`default_nettype wire

/* source/ext_subsystem_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// External peripheral subsystem top: register-bus demultiplexer, slow
// memory, GPIO counter, switch acknowledge model, interrupt collector
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module ext_subsystem_top import ext_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        gpio_i,
  output logic        gpio_o,
  input  domain_vec_t switch_n_i,
  output domain_vec_t switch_ack_n_o,
  output intr_vec_t   intr_o
);

  reg_req_t [N_PERIPH-1:0] periph_req;
  reg_rsp_t [N_PERIPH-1:0] periph_rsp;
  logic                    cnt_event;
  logic                    ack_event;

  reg_demux u_reg_demux (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (reg_req_i),
    .rsp_o        (reg_rsp_o),
    .periph_req_o (periph_req),
    .periph_rsp_i (periph_rsp)
  );

  slow_memory u_slow_memory (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (periph_req[MEM_IDX]),
    .rsp_o   (periph_rsp[MEM_IDX])
  );

  gpio_cnt u_gpio_cnt (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .req_i       (periph_req[GPIO_CNT_IDX]),
    .rsp_o       (periph_rsp[GPIO_CNT_IDX]),
    .cnt_event_o (cnt_event)
  );

  // Stands in for the external domain switch cells
  switch_ack_delay u_switch_ack_delay (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .switch_n_i     (switch_n_i),
    .switch_ack_n_o (switch_ack_n_o),
    .ack_event_o    (ack_event)
  );

  intr_collect u_intr_collect (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cnt_event_i (cnt_event),
    .ack_event_i (ack_event),
    .req_i       (periph_req[INTR_IDX]),
    .rsp_o       (periph_rsp[INTR_IDX]),
    .intr_o      (intr_o)
  );

endmodule

`default_nettype wire

/* verification/tb_ext_tests.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests: reset values, slow memory, unmapped windows, GPIO
// counter, switch acknowledge and interrupts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_values();
    int       err_start;
    int       cycles;
    reg_rsp_t rsp;
    err_start = err_cnt;
    @(negedge clk);
    check_domain("switch_ack_n_o", switch_ack_n, '1);
    check_bit("gpio_o", gpio_out, 1'b0);
    check_intr("intr_o", intr, '0);
    bus_read(win_addr(GPIO_CNT_IDX, 0), rsp, cycles);
    check_data("gpio count", rsp.rdata, '0);
    bus_read(win_addr(INTR_IDX, 0), rsp, cycles);
    check_data("intr pending", rsp.rdata, '0);
    finish_test("reset values", err_start);
  endtask

  task automatic test_slow_memory();
    int        err_start;
    int        cycles;
    reg_rsp_t  rsp;
    data_t     rnd;
    data_t     wdata;
    mem_addr_t idx;
    err_start = err_cnt;
    // Full-word fill first so later strobed writes start from known data
    for (int i = 0; i < MEM_USED; i++) begin
      rnd         = rand_word();
      used_idx[i] = rnd[SLOW_MEM_ADDR_W-1:0];
      wdata       = rand_word();
      bus_write(mem_addr(used_idx[i], 2'b00), wdata, '1, rsp, cycles);
      mem_model[used_idx[i]] = wdata;
      check_cycles("memory write latency", cycles, SLOW_MEM_LATENCY + 1);
    end
    for (int i = 0; i < MEM_WRITES; i++) begin
      rnd   = rand_word();
      idx   = used_idx[int'(rnd[7:0]) % MEM_USED];
      wdata = rand_word();
      bus_write(mem_addr(idx, rnd[13:12]), wdata, rnd[11:8], rsp, cycles);
      mem_model[idx] = apply_strobe(mem_model[idx], wdata, rnd[11:8]);
      check_cycles("memory write latency", cycles, SLOW_MEM_LATENCY + 1);
    end
    for (int i = 0; i < MEM_USED; i++) begin
      rnd = rand_word();
      bus_read(mem_addr(used_idx[i], rnd[1:0]), rsp, cycles);
      check_data("memory rdata", rsp.rdata, mem_model[used_idx[i]]);
      check_bit("memory error", rsp.error, 1'b0);
      check_cycles("memory read latency", cycles, SLOW_MEM_LATENCY + 1);
    end
    finish_test("slow memory", err_start);
  endtask

  task automatic test_unmapped_window();
    int       err_start;
    int       cycles;
    reg_rsp_t rsp;
    addr_t    upper_addr;
    err_start  = err_cnt;
    // Would hit the memory word if bits 31:16 were ignored
    upper_addr = 32'h0001_0000 | mem_addr(used_idx[0], 2'b00);
    bus_write(win_addr(3, int'(used_idx[0]) * 4), ~mem_model[used_idx[0]], '1, rsp, cycles);
    check_bit("window 3 write error", rsp.error, 1'b1);
    check_cycles("window 3 write latency", cycles, 1);
    bus_read(win_addr(3, int'(used_idx[0]) * 4), rsp, cycles);
    check_bit("window 3 read error", rsp.error, 1'b1);
    check_data("window 3 rdata", rsp.rdata, '0);
    check_cycles("window 3 read latency", cycles, 1);
    bus_write(upper_addr, ~mem_model[used_idx[0]], '1, rsp, cycles);
    check_bit("upper address write error", rsp.error, 1'b1);
    check_cycles("upper address write latency", cycles, 1);
    bus_read(upper_addr, rsp, cycles);
    check_bit("upper address read error", rsp.error, 1'b1);
    check_data("upper address rdata", rsp.rdata, '0);
    check_cycles("upper address read latency", cycles, 1);
    bus_read(mem_addr(used_idx[0], 2'b00), rsp, cycles);
    check_data("memory after unmapped writes", rsp.rdata, mem_model[used_idx[0]]);
    finish_test("unmapped window", err_start);
  endtask

  task automatic test_gpio_counter();
    int       err_start;
    int       cycles;
    reg_rsp_t rsp;
    err_start = err_cnt;
    pulse_gpio(3);
    @(negedge clk);
    check_bit("gpio_o before limit", gpio_out, gpio_exp);
    bus_read(win_addr(GPIO_CNT_IDX, 0), rsp, cycles);
    check_data("gpio count", rsp.rdata, data_t'(gpio_edges));
    check_cycles("gpio read latency", cycles, 1);
    pulse_gpio(GPIO_CNT_MAX - 3);
    @(negedge clk);
    check_bit("gpio_o at limit", gpio_out, gpio_exp);
    bus_read(win_addr(GPIO_CNT_IDX, 0), rsp, cycles);
    check_data("gpio count at limit", rsp.rdata, data_t'(gpio_edges));
    pulse_gpio(2);
    bus_write(win_addr(GPIO_CNT_IDX, 0), rand_word(), '1, rsp, cycles);
    gpio_edges = 0;
    bus_read(win_addr(GPIO_CNT_IDX, 0), rsp, cycles);
    check_data("gpio count after clear", rsp.rdata, '0);
    finish_test("gpio counter", err_start);
  endtask

  task automatic test_switch_ack();
    int err_start;
    err_start = err_cnt;
    follow_switch(ack_exp ^ domain_vec_t'(1));
    follow_switch(~ack_exp);
    follow_switch('1);
    finish_test("switch acknowledge", err_start);
  endtask

  task automatic test_interrupts();
    int        err_start;
    int        cycles;
    reg_rsp_t  rsp;
    intr_vec_t gpio_mask;
    intr_vec_t sw_mask;
    err_start                = err_cnt;
    gpio_mask                = '0;
    gpio_mask[INTR_GPIO_BIT] = 1'b1;
    sw_mask                  = '0;
    sw_mask[INTR_SWITCH_BIT] = 1'b1;
    // Drop events left over from the earlier tests
    bus_write(win_addr(INTR_IDX, 0), '1, '1, rsp, cycles);
    bus_read(win_addr(INTR_IDX, 0), rsp, cycles);
    check_data("intr pending cleared", rsp.rdata, '0);
    bus_write(win_addr(INTR_IDX, 4), data_t'(gpio_mask), '1, rsp, cycles);
    bus_read(win_addr(INTR_IDX, 4), rsp, cycles);
    check_data("intr enable", rsp.rdata, data_t'(gpio_mask));
    pulse_gpio(GPIO_CNT_MAX);
    follow_switch(~ack_exp);
    wait_cycles(3);
    check_intr("intr_o switch masked", intr, gpio_mask);
    bus_read(win_addr(INTR_IDX, 0), rsp, cycles);
    check_data("intr pending", rsp.rdata, data_t'(gpio_mask | sw_mask));
    bus_write(win_addr(INTR_IDX, 4), data_t'(gpio_mask | sw_mask), '1, rsp, cycles);
    wait_cycles(2);
    check_intr("intr_o both enabled", intr, gpio_mask | sw_mask);
    bus_write(win_addr(INTR_IDX, 0), data_t'(gpio_mask), '1, rsp, cycles);
    wait_cycles(2);
    check_intr("intr_o after clear", intr, sw_mask);
    bus_read(win_addr(INTR_IDX, 0), rsp, cycles);
    check_data("intr pending after clear", rsp.rdata, data_t'(sw_mask));
    finish_test("interrupts", err_start);
  endtask

/* verification/tb_ext_subsystem.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top: clock, reset, DUT, watchdog, xorshift source, bus and
// compare tasks, and the test sequence
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_ext_subsystem import ext_bus_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DLY    = 1;
  localparam int RESET_CYCLES = 10;
  localparam int BUS_TIMEOUT  = 16;
  localparam int MEM_USED     = 8;
  localparam int MEM_WRITES   = 12;
  localparam int MEM_XFER     = SLOW_MEM_LATENCY + 2;
  // Budget per test: reset, memory, unmapped, GPIO, switch, interrupts
  localparam int TEST_CYCLES  = RESET_CYCLES + 6 + (2 * MEM_USED + MEM_WRITES) * MEM_XFER +
                                4 * MEM_XFER + 4 * GPIO_CNT_MAX + 10 +
                                4 * (SWITCH_ACK_LATENCY + 2) + 2 * GPIO_CNT_MAX + 30;
  localparam int WATCHDOG_NS  = (2 * TEST_CYCLES + 100) * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  logic        gpio_in;
  logic        gpio_out;
  domain_vec_t switch_n;
  domain_vec_t switch_ack_n;
  intr_vec_t   intr;
  int          err_cnt;
  int          test_cnt;
  int          failed_tests;
  logic [31:0] rng_state;

  // Reference state carried from test to test
  data_t       mem_model [SLOW_MEM_WORDS];
  mem_addr_t   used_idx [MEM_USED];
  int          gpio_edges;
  logic        gpio_exp;
  domain_vec_t ack_exp;

  ext_subsystem_top u_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .reg_req_i      (reg_req),
    .reg_rsp_o      (reg_rsp),
    .gpio_i         (gpio_in),
    .gpio_o         (gpio_out),
    .switch_n_i     (switch_n),
    .switch_ack_n_o (switch_ack_n),
    .intr_o         (intr)
  );

  always begin
    clk = 1'b0;
    #(CLK_PERIOD / 2);
    clk = 1'b1;
    #(CLK_PERIOD / 2);
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t rand_word();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic addr_t win_addr(input int win, input int offset);
    return addr_t'(win << WINDOW_BITS) | addr_t'(offset);
  endfunction

  // Bits 11:10 select an alias of the same word
  function automatic addr_t mem_addr(input mem_addr_t idx, input logic [1:0] alias_bits);
    return (addr_t'(MEM_IDX) << WINDOW_BITS) | addr_t'({alias_bits, idx, 2'b00});
  endfunction

  function automatic data_t apply_strobe(input data_t old, input data_t wr, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wr[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_domain(input string name, input domain_vec_t got, input domain_vec_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_intr(input string name, input intr_vec_t got, input intr_vec_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t: %s = %0d cycles, expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Valid is held until ready is seen, cycles counts edges up to completion
  task automatic bus_xfer(input reg_req_t req, output reg_rsp_t rsp, output int cycles);
    logic done;
    done   = 1'b0;
    cycles = 0;
    rsp    = '0;
    @(posedge clk);
    #DRIVE_DLY;
    reg_req = req;
    while (!done && cycles < BUS_TIMEOUT) begin
      @(negedge clk);
      rsp  = reg_rsp;
      done = rsp.ready;
      cycles++;
      @(posedge clk);
      #DRIVE_DLY;
    end
    reg_req = '0;
    if (!done) begin
      $display("Bus transfer to 0x%08h saw no ready within %0d cycles", req.addr, BUS_TIMEOUT);
      err_cnt++;
    end
  endtask

  task automatic bus_write(input addr_t addr, input data_t data, input strb_t strb,
                           output reg_rsp_t rsp, output int cycles);
    bus_xfer('{valid: 1'b1, write: 1'b1, addr: addr, wdata: data, wstrb: strb}, rsp, cycles);
  endtask

  task automatic bus_read(input addr_t addr, output reg_rsp_t rsp, output int cycles);
    bus_xfer('{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0, wstrb: '0}, rsp, cycles);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  // Each pulse is one rising edge, tracked against the counter rule
  task automatic pulse_gpio(input int n);
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DLY;
      gpio_in = 1'b1;
      @(posedge clk);
      #DRIVE_DLY;
      gpio_in = 1'b0;
      gpio_edges++;
      if (gpio_edges == GPIO_CNT_MAX) begin
        gpio_edges = 0;
        gpio_exp   = !gpio_exp;
      end
    end
  endtask

  // Acknowledge must hold its old value until the last delay edge
  task automatic follow_switch(input domain_vec_t new_val);
    @(posedge clk);
    #DRIVE_DLY;
    switch_n = new_val;
    for (int i = 1; i <= SWITCH_ACK_LATENCY; i++) begin
      @(posedge clk);
      @(negedge clk);
      if (i == SWITCH_ACK_LATENCY) begin
        ack_exp = new_val;
      end
      check_domain("switch_ack_n_o", switch_ack_n, ack_exp);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("[%0t] %s: ok", $time, name);
    end else begin
      failed_tests++;
      $display("[%0t] %s: %0d mismatches", $time, name, err_cnt - err_start);
    end
  endtask

`include "tb_ext_tests.svh"

  initial begin
    rng_state    = 32'd19289;
    err_cnt      = 0;
    test_cnt     = 0;
    failed_tests = 0;
    gpio_edges   = 0;
    gpio_exp     = 1'b0;
    ack_exp      = '1;
    rst_n        = 1'b0;
    reg_req      = '0;
    gpio_in      = 1'b0;
    switch_n     = '1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    test_reset_values();
    test_slow_memory();
    test_unmapped_window();
    test_gpio_counter();
    test_switch_ack();
    test_interrupts();
    $display("Summary: %0d tests run, %0d failed, %0d mismatches",
             test_cnt, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verification
common/ext_bus_pkg.sv
source/reg_demux.sv
slow_memory/slow_memory.sv
source/gpio_cnt.sv
source/switch_ack_delay.sv
source/intr_collect.sv
source/ext_subsystem_top.sv
verification/tb_ext_subsystem.sv

/* Makefile */
# Verilator lint, simulation and clean targets

VERILATOR  ?= verilator
TOP        := tb_ext_subsystem
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!
COMMON_FLAGS := --timing --timescale 1ns/1ns --top-module $(TOP)
LINT_FLAGS := --lint-only $(COMMON_FLAGS)
SIM_FLAGS  := --binary -j 0 $(COMMON_FLAGS) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
